// File: hdl/apb_host_port.sv
`timescale 1ns/1ps

module apb_host_port (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  cpu_bus_pkg::apb_addr_t  paddr,
    input  cpu_isa_pkg::word_t      pwdata,
    input  logic                    halted,
    input  cpu_isa_pkg::word_t      host_dmem_rdata,
    output cpu_isa_pkg::word_t      prdata,
    output logic                    pready,
    output logic                    pslverr,
    output logic                    start,
    output logic                    imem_we,
    output cpu_bus_pkg::mem_index_t imem_index,
    output cpu_isa_pkg::word_t      imem_wdata,
    output logic                    host_dmem_we,
    output cpu_bus_pkg::mem_index_t host_dmem_index,
    output cpu_isa_pkg::word_t      host_dmem_wdata
);

    typedef enum logic [1:0] {st_idle, st_running, st_finished} run_state_t;

    run_state_t state;
    logic       access, busy, done;
    logic       is_ctrl, is_status, in_imem, in_dmem;
    logic       dmem_read, wait_q, err, xfer_wr;

    assign access    = psel && penable;
    assign busy      = (state == st_running);
    assign done      = (state == st_finished);

    //////////////////////////////
    // Address decode
    assign is_ctrl   = (paddr == cpu_bus_pkg::ADDR_CTRL);
    assign is_status = (paddr == cpu_bus_pkg::ADDR_STATUS);
    assign in_imem   = (paddr >= cpu_bus_pkg::IMEM_BASE) &&
                       (paddr <  cpu_bus_pkg::IMEM_BASE + cpu_bus_pkg::WINDOW_BYTES);
    assign in_dmem   = (paddr >= cpu_bus_pkg::DMEM_BASE) &&
                       (paddr <  cpu_bus_pkg::DMEM_BASE + cpu_bus_pkg::WINDOW_BYTES);
    assign dmem_read = in_dmem && !pwrite && !busy;   // Needs one wait state

    // Windows are locked during a run and the instruction window is write only
    assign err = !(is_ctrl || is_status || in_imem || in_dmem) ||
                 ((in_imem || in_dmem) && busy) || (in_imem && !pwrite);

    assign pready  = access && (!dmem_read || wait_q);
    assign pslverr = pready && err;
    assign xfer_wr = pready && pwrite && !err;
    assign prdata  = is_status ? {30'b0, done, busy} :
                     in_dmem   ? host_dmem_rdata : '0;

    assign start           = xfer_wr && is_ctrl && pwdata[0] && !busy;
    assign imem_we         = xfer_wr && in_imem;
    assign imem_index      = paddr[7:2];
    assign imem_wdata      = pwdata;
    assign host_dmem_we    = xfer_wr && in_dmem;
    assign host_dmem_index = paddr[7:2];
    assign host_dmem_wdata = pwdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= st_idle;
            wait_q <= 1'b0;
        end else begin
            wait_q <= access && dmem_read && !wait_q;
            case (state)
                st_idle, st_finished: begin
                    if (start) begin
                        state <= st_running;     // Clears done
                    end
                end
                st_running: begin
                    if (halted) begin
                        state <= st_finished;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: hdl/cpu_bus_pkg.sv
package cpu_bus_pkg;

    typedef logic [11:0] apb_addr_t;   // APB byte address
    typedef logic [5:0]  mem_index_t;  // Word index into either memory

    localparam int MEM_WORDS = 64;

    //////////////////////////////
    // APB register map
    localparam apb_addr_t ADDR_CTRL    = 12'h000;  // Bit 0 starts a run
    localparam apb_addr_t ADDR_STATUS  = 12'h004;  // Bit 0 busy, bit 1 done
    localparam apb_addr_t IMEM_BASE    = 12'h400;
    localparam apb_addr_t DMEM_BASE    = 12'h800;
    localparam apb_addr_t WINDOW_BYTES = 12'h100;

endpackage

// File: hdl/cpu_isa_pkg.sv
package cpu_isa_pkg;

    typedef logic [31:0] word_t;       // Data or instruction word
    typedef logic [4:0]  reg_addr_t;
    // Opcode followed by funct3, or by funct7 bits 5, 1 and 0 for R type
    typedef logic [9:0]  op_t;

    //////////////////////////////
    // Major opcodes
    localparam logic [6:0] OPC_R      = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    //////////////////////////////
    // Operation codes seen by execute
    localparam op_t OP_ADD  = {OPC_R, 3'b000};
    localparam op_t OP_SUB  = {OPC_R, 3'b100};      // funct7 bit 5 set
    localparam op_t OP_MUL  = {OPC_R, 3'b001};      // funct7 bit 0 set
    localparam op_t OP_LDB  = {OPC_LOAD, 3'b000};
    localparam op_t OP_LDW  = {OPC_LOAD, 3'b010};
    localparam op_t OP_ADDI = {OPC_IMM, 3'b000};
    localparam op_t OP_STB  = {OPC_STORE, 3'b000};
    localparam op_t OP_STW  = {OPC_STORE, 3'b010};
    localparam op_t OP_BEQ  = {OPC_BRANCH, 3'b000};
    localparam op_t OP_JAL  = {OPC_JAL, 3'b000};    // J type has no funct3

endpackage

// File: hdl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  cpu_bus_pkg::apb_addr_t paddr,
    input  cpu_isa_pkg::word_t     pwdata,
    output cpu_isa_pkg::word_t     prdata,
    output logic                   pready,
    output logic                   pslverr
);

    // Host port and pipeline control
    logic                    start, halted, stall, redirect;
    logic                    imem_we, host_dmem_we;
    cpu_bus_pkg::mem_index_t imem_index, host_dmem_index;
    cpu_isa_pkg::word_t      imem_wdata, host_dmem_wdata, host_dmem_rdata, redirect_pc;

    // Fetch to decode
    logic                    if_valid;
    cpu_isa_pkg::word_t      if_pc, if_instr;

    // Decode to execute
    logic                    id_valid, id_use_immed, id_reg_write, id_mem_read, id_mem_write;
    logic                    id_byte, id_branch, id_jump, id_halt;
    cpu_isa_pkg::op_t        id_op;
    cpu_isa_pkg::reg_addr_t  id_rd;
    cpu_isa_pkg::word_t      id_pc, id_rs1_val, id_rs2_val, id_immed;

    // Execute to memory
    logic                    ex_valid, ex_reg_write, ex_mem_read, ex_mem_write, ex_byte, ex_halt;
    cpu_isa_pkg::reg_addr_t  ex_rd;
    cpu_isa_pkg::word_t      ex_result, ex_store_data;

    // Writeback into the register file
    logic                    mem_valid, mem_reg_write, wb_we;
    cpu_isa_pkg::reg_addr_t  mem_rd, wb_addr;
    cpu_isa_pkg::word_t      wb_data;

    apb_host_port u_apb     (.*);
    fetch_stage   u_fetch   (.*);
    decode_stage  u_decode  (.*);
    execute_stage u_execute (.*);
    memory_stage  u_memory  (.*);

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   if_valid,
    input  cpu_isa_pkg::word_t     if_pc,
    input  cpu_isa_pkg::word_t     if_instr,
    input  logic                   redirect,
    input  logic                   ex_valid,
    input  cpu_isa_pkg::reg_addr_t ex_rd,
    input  logic                   ex_reg_write,
    input  logic                   mem_valid,
    input  cpu_isa_pkg::reg_addr_t mem_rd,
    input  logic                   mem_reg_write,
    input  logic                   wb_we,
    input  cpu_isa_pkg::reg_addr_t wb_addr,
    input  cpu_isa_pkg::word_t     wb_data,
    output logic                   stall,
    output logic                   id_valid,
    output cpu_isa_pkg::word_t     id_pc,
    output cpu_isa_pkg::op_t       id_op,
    output cpu_isa_pkg::word_t     id_rs1_val,
    output cpu_isa_pkg::word_t     id_rs2_val,
    output cpu_isa_pkg::word_t     id_immed,
    output cpu_isa_pkg::reg_addr_t id_rd,
    output logic                   id_use_immed,
    output logic                   id_reg_write,
    output logic                   id_mem_read,
    output logic                   id_mem_write,
    output logic                   id_byte,
    output logic                   id_branch,
    output logic                   id_jump,
    output logic                   id_halt
);

    cpu_isa_pkg::word_t     regs [32];
    logic [6:0]             opcode;
    cpu_isa_pkg::op_t       op;
    cpu_isa_pkg::reg_addr_t rs1, rs2, rd;
    cpu_isa_pkg::word_t     immed;
    logic [8:0]             ctrl;
    logic                   use_rs1, use_rs2, use_immed, reg_write;
    logic                   mem_read, mem_write, branch, jump, halt, is_byte;
    logic [31:0]            pend;       // Registers with a write still in flight
    logic                   hazard, halt_seen, issue;

    assign opcode = if_instr[6:0];
    assign rs1    = if_instr[19:15];
    assign rs2    = if_instr[24:20];
    assign rd     = if_instr[11:7];
    assign op     = (opcode == cpu_isa_pkg::OPC_R)   ? {opcode, if_instr[30], if_instr[26:25]} :
                    (opcode == cpu_isa_pkg::OPC_JAL) ? {opcode, 3'b000} :
                                                       {opcode, if_instr[14:12]};

    //////////////////////////////
    // Instruction decode
    always_comb begin
        case (opcode)
            cpu_isa_pkg::OPC_STORE:
                immed = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
            cpu_isa_pkg::OPC_BRANCH:
                immed = {{19{if_instr[31]}}, if_instr[31], if_instr[7], if_instr[30:25],
                         if_instr[11:8], 1'b0};
            cpu_isa_pkg::OPC_JAL:
                immed = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12], if_instr[20],
                         if_instr[30:21], 1'b0};
            default:
                immed = {{20{if_instr[31]}}, if_instr[31:20]};      // I layout
        endcase
    end

    // rs1 rs2 imm | wr rd st | br jmp halt
    always_comb begin
        case (op)
            cpu_isa_pkg::OP_ADD, cpu_isa_pkg::OP_SUB, cpu_isa_pkg::OP_MUL: ctrl = 9'b110_100_000;
            cpu_isa_pkg::OP_LDB, cpu_isa_pkg::OP_LDW: ctrl = 9'b101_110_000;
            cpu_isa_pkg::OP_ADDI:                     ctrl = 9'b101_100_000;
            cpu_isa_pkg::OP_STB, cpu_isa_pkg::OP_STW: ctrl = 9'b111_001_000;
            cpu_isa_pkg::OP_BEQ:                      ctrl = 9'b110_000_100;
            cpu_isa_pkg::OP_JAL:                      ctrl = 9'b000_100_010;
            default:                                  ctrl = 9'b000_000_001;  // Halt marker
        endcase
    end

    assign {use_rs1, use_rs2, use_immed, reg_write, mem_read, mem_write,
            branch, jump, halt} = ctrl;
    assign is_byte = (op == cpu_isa_pkg::OP_LDB) || (op == cpu_isa_pkg::OP_STB);

    //////////////////////////////
    // Hazard stall
    always_comb begin
        pend = '0;
        if (id_valid && id_reg_write) begin
            pend[id_rd] = 1'b1;
        end
        if (ex_valid && ex_reg_write) begin
            pend[ex_rd] = 1'b1;
        end
        if (mem_valid && mem_reg_write) begin
            pend[mem_rd] = 1'b1;
        end
        pend[0] = 1'b0;                   // x0 never waits
    end

    assign hazard = if_valid && ((use_rs1 && pend[rs1]) || (use_rs2 && pend[rs2]));
    assign stall  = hazard || halt_seen;  // Nothing issues behind a halt
    assign issue  = if_valid && !stall && !redirect;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid  <= 1'b0;
            halt_seen <= 1'b0;
        end else begin
            id_valid <= issue;
            if (!if_valid) begin
                halt_seen <= 1'b0;        // Fetch drops valid once the run ends
            end else if (issue && halt) begin
                halt_seen <= 1'b1;
            end
        end
    end

    // Register file and decoded fields
    always_ff @(posedge clk) begin
        if (wb_we) begin
            regs[wb_addr] <= wb_data;
        end
        id_pc        <= if_pc;
        id_op        <= op;
        id_rs1_val   <= (rs1 == '0) ? '0 : regs[rs1];
        id_rs2_val   <= (rs2 == '0) ? '0 : regs[rs2];
        id_immed     <= immed;
        id_rd        <= rd;
        id_use_immed <= use_immed;
        id_reg_write <= reg_write;
        id_mem_read  <= mem_read;
        id_mem_write <= mem_write;
        id_byte      <= is_byte;
        id_branch    <= branch;
        id_jump      <= jump;
        id_halt      <= halt;
    end

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   id_valid,
    input  cpu_isa_pkg::word_t     id_pc,
    input  cpu_isa_pkg::op_t       id_op,
    input  cpu_isa_pkg::word_t     id_rs1_val,
    input  cpu_isa_pkg::word_t     id_rs2_val,
    input  cpu_isa_pkg::word_t     id_immed,
    input  cpu_isa_pkg::reg_addr_t id_rd,
    input  logic                   id_use_immed,
    input  logic                   id_reg_write,
    input  logic                   id_mem_read,
    input  logic                   id_mem_write,
    input  logic                   id_byte,
    input  logic                   id_branch,
    input  logic                   id_jump,
    input  logic                   id_halt,
    output logic                   redirect,
    output cpu_isa_pkg::word_t     redirect_pc,
    output logic                   ex_valid,
    output cpu_isa_pkg::reg_addr_t ex_rd,
    output logic                   ex_reg_write,
    output cpu_isa_pkg::word_t     ex_result,
    output cpu_isa_pkg::word_t     ex_store_data,
    output logic                   ex_mem_read,
    output logic                   ex_mem_write,
    output logic                   ex_byte,
    output logic                   ex_halt
);

    cpu_isa_pkg::word_t op_b;
    cpu_isa_pkg::word_t alu;

    assign op_b = id_use_immed ? id_immed : id_rs2_val;

    always_comb begin
        case (id_op)
            cpu_isa_pkg::OP_SUB: alu = id_rs1_val - op_b;
            cpu_isa_pkg::OP_MUL: alu = id_rs1_val * op_b;    // Low 32 bits kept
            cpu_isa_pkg::OP_JAL: alu = id_pc + 32'd4;        // Link address
            default:             alu = id_rs1_val + op_b;    // Also load/store address
        endcase
    end

    // Taken branch or jump flushes fetch and decode
    assign redirect    = id_valid && (id_jump || (id_branch && (id_rs1_val == id_rs2_val)));
    assign redirect_pc = id_pc + id_immed;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid     <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_halt      <= 1'b0;
        end else begin
            ex_valid     <= id_valid;
            ex_reg_write <= id_valid && id_reg_write;
            ex_mem_read  <= id_valid && id_mem_read;
            ex_mem_write <= id_valid && id_mem_write;
            ex_halt      <= id_valid && id_halt;
        end
    end

    always_ff @(posedge clk) begin
        ex_rd         <= id_rd;
        ex_result     <= alu;
        ex_store_data <= id_rs2_val;
        ex_byte       <= id_byte;
    end

endmodule

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic                    stall,
    input  logic                    redirect,
    input  cpu_isa_pkg::word_t      redirect_pc,
    input  logic                    halted,
    input  logic                    imem_we,
    input  cpu_bus_pkg::mem_index_t imem_index,
    input  cpu_isa_pkg::word_t      imem_wdata,
    output logic                    if_valid,
    output cpu_isa_pkg::word_t      if_pc,
    output cpu_isa_pkg::word_t      if_instr
);

    cpu_isa_pkg::word_t imem [cpu_bus_pkg::MEM_WORDS];
    cpu_isa_pkg::word_t pc;
    logic               running;
    logic               fetch_en;

    assign fetch_en = running && !stall;

    // Host write port and the synchronous read for the pipeline
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_index] <= imem_wdata;
        end
        if (fetch_en) begin
            if_instr <= imem[pc[7:2]];
            if_pc    <= pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running  <= 1'b0;
            pc       <= '0;
            if_valid <= 1'b0;
        end else if (start) begin
            running  <= 1'b1;
            pc       <= '0;
            if_valid <= 1'b0;
        end else if (halted) begin
            running  <= 1'b0;
            if_valid <= 1'b0;
        end else if (redirect) begin
            pc       <= redirect_pc;     // Word in flight is dropped
            if_valid <= 1'b0;
        end else if (fetch_en) begin
            pc       <= pc + 32'd4;
            if_valid <= 1'b1;
        end
    end

endmodule

// File: hdl/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ex_valid,
    input  cpu_isa_pkg::reg_addr_t  ex_rd,
    input  logic                    ex_reg_write,
    input  cpu_isa_pkg::word_t      ex_result,
    input  cpu_isa_pkg::word_t      ex_store_data,
    input  logic                    ex_mem_read,
    input  logic                    ex_mem_write,
    input  logic                    ex_byte,
    input  logic                    ex_halt,
    input  logic                    host_dmem_we,
    input  cpu_bus_pkg::mem_index_t host_dmem_index,
    input  cpu_isa_pkg::word_t      host_dmem_wdata,
    output logic                    mem_valid,
    output cpu_isa_pkg::reg_addr_t  mem_rd,
    output logic                    mem_reg_write,
    output cpu_isa_pkg::word_t      host_dmem_rdata,
    output logic                    wb_we,
    output cpu_isa_pkg::reg_addr_t  wb_addr,
    output cpu_isa_pkg::word_t      wb_data,
    output logic                    halted
);

    cpu_isa_pkg::word_t      dmem [cpu_bus_pkg::MEM_WORDS];
    cpu_bus_pkg::mem_index_t port_index;
    cpu_isa_pkg::word_t      port_wdata, rdata_q, result_q;
    logic [3:0]              port_be;
    logic [1:0]              lane_q;
    logic [7:0]              load_byte;
    logic                    load_q, byte_q, halt_q;

    // The host owns the RAM port whenever no instruction is in the stage
    always_comb begin
        if (ex_valid) begin
            port_index = ex_result[7:2];
            port_wdata = ex_byte ? {4{ex_store_data[7:0]}} : ex_store_data;
            if (!ex_mem_write) begin
                port_be = 4'b0000;
            end else if (ex_byte) begin
                port_be = 4'b0001 << ex_result[1:0];
            end else begin
                port_be = 4'b1111;
            end
        end else begin
            port_index = host_dmem_index;
            port_wdata = host_dmem_wdata;
            port_be    = {4{host_dmem_we}};
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (port_be[b]) begin
                dmem[port_index][8*b +: 8] <= port_wdata[8*b +: 8];
            end
        end
        rdata_q  <= dmem[port_index];
        result_q <= ex_result;
        lane_q   <= ex_result[1:0];
        byte_q   <= ex_byte;
        mem_rd   <= ex_rd;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid     <= 1'b0;
            mem_reg_write <= 1'b0;
            load_q        <= 1'b0;
            halt_q        <= 1'b0;
        end else begin
            mem_valid     <= ex_valid;
            mem_reg_write <= ex_reg_write;
            load_q        <= ex_mem_read;
            halt_q        <= ex_halt;
        end
    end

    //////////////////////////////
    // Writeback
    assign load_byte       = rdata_q[8*lane_q +: 8];
    assign host_dmem_rdata = rdata_q;
    assign wb_we   = mem_valid && mem_reg_write && (mem_rd != '0);
    assign wb_addr = mem_rd;
    assign wb_data = !load_q ? result_q :
                     byte_q  ? {{24{load_byte[7]}}, load_byte} : rdata_q;
    assign halted  = mem_valid && halt_q;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the CPU testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f src.f -o cpu_sim

# The log decides the result, so the exit status of the simulator is not used here
./obj_dir/cpu_sim | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// File: src.f
hdl/cpu_isa_pkg.sv
hdl/cpu_bus_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/apb_host_port.sv
hdl/cpu_top.sv
verification/cpu_checker.sv
verification/cpu_tb.sv

// File: verification/cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   psel,
    input logic                   penable,
    input logic                   pwrite,
    input cpu_bus_pkg::apb_addr_t paddr,
    input logic                   pready,
    input logic                   pslverr,
    input logic                   wb_we,
    input cpu_isa_pkg::reg_addr_t wb_addr
);

    //////////////////////////////
    // APB rules
    apb_hold: assert property (@(posedge clk) disable iff (!rst_n)
        psel && !pready |=> $stable(paddr) && $stable(pwrite))
        else $error("APB address or direction changed before the transfer ended");

    apb_enable: assert property (@(posedge clk) disable iff (!rst_n) penable |-> psel)
        else $error("APB penable high without psel");

    apb_error: assert property (@(posedge clk) disable iff (!rst_n) pslverr |-> pready)
        else $error("APB pslverr high without pready");

    //////////////////////////////
    // Register file
    x0_write: assert property (@(posedge clk) disable iff (!rst_n) wb_we |-> wb_addr != '0)
        else $error("Register file written at x0");

endmodule

// Port side; the writeback inputs are tied off
bind apb_host_port cpu_checker apb_rules_i (
    .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pready(pready), .pslverr(pslverr), .wb_we(1'b0), .wb_addr(5'd0)
);

// Decode side; the bus inputs are tied off
bind decode_stage cpu_checker regfile_rules_i (
    .clk(clk), .rst_n(rst_n), .psel(1'b0), .penable(1'b0), .pwrite(1'b0),
    .paddr(12'h000), .pready(1'b0), .pslverr(1'b0), .wb_we(wb_we), .wb_addr(wb_addr)
);

// File: verification/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

    localparam int N_TESTS     = 5;
    localparam int PROG_WORDS  = 12;
    localparam int MAX_EXP     = 4;
    localparam int APB_TIMEOUT = 16;      // Cycles per APB transfer
    localparam int RUN_TIMEOUT = 200;     // STATUS polls per run
    localparam int PRELOAD_IDX = 32;      // Byte address 0x80
    localparam int LOCK_IDX    = 63;
    localparam logic [6:0] F7_ADD = 7'h00;
    localparam logic [6:0] F7_SUB = 7'h20;
    localparam logic [6:0] F7_MUL = 7'h01;
    localparam logic [2:0] F3_B   = 3'b000;
    localparam logic [2:0] F3_W   = 3'b010;
    localparam cpu_isa_pkg::word_t HALT = 32'h0000_0000;   // Opcode 0 is not in the ISA

    logic                   clk, rst_n, psel, penable, pwrite, pready, pslverr;
    cpu_bus_pkg::apb_addr_t paddr;
    cpu_isa_pkg::word_t     pwdata, prdata;
    int                     mismatches, timeouts;
    string                  cur_test;

    // Test table
    string              test_name [N_TESTS];
    cpu_isa_pkg::word_t prog [N_TESTS][PROG_WORDS];
    cpu_isa_pkg::word_t preload [N_TESTS];
    int                 exp_count [N_TESTS];
    int                 exp_index [N_TESTS][MAX_EXP];
    cpu_isa_pkg::word_t exp_word [N_TESTS][MAX_EXP];
    logic               lock_check [N_TESTS];    // Try a data write while busy

    cpu_top dut_i (
        .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    //////////////////////////////
    // Instruction encoding
    function automatic cpu_isa_pkg::word_t r_op(input logic [6:0] f7, input int rd,
                                                input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
    endfunction

    function automatic cpu_isa_pkg::word_t addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic cpu_isa_pkg::word_t load(input logic [2:0] f3, input int rd,
                                                input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], 7'b0000011};
    endfunction

    function automatic cpu_isa_pkg::word_t store(input logic [2:0] f3, input int rs2,
                                                 input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic cpu_isa_pkg::word_t beq(input int rs1, input int rs2, input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic cpu_isa_pkg::word_t jal(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic build_table();
        test_name = '{"arith", "hazard", "memory", "branch", "jump"};
        prog[0] = '{addi(1, 0, -7), addi(2, 0, 12), r_op(F7_ADD, 3, 1, 2),
                    r_op(F7_SUB, 4, 1, 2), r_op(F7_MUL, 5, 1, 2), addi(6, 1, -2000),
                    store(F3_W, 3, 0, 0), store(F3_W, 4, 0, 4), store(F3_W, 5, 0, 8),
                    store(F3_W, 6, 0, 12), HALT, HALT};
        prog[1] = '{addi(1, 0, 3), r_op(F7_ADD, 2, 1, 1), r_op(F7_MUL, 3, 2, 1),
                    r_op(F7_SUB, 4, 3, 2), addi(4, 4, 100), r_op(F7_ADD, 5, 4, 3),
                    store(F3_W, 5, 0, 16), store(F3_W, 4, 0, 20), r_op(F7_MUL, 6, 5, 5),
                    store(F3_W, 6, 0, 24), HALT, HALT};
        prog[2] = '{addi(1, 0, 'h11), addi(2, 0, -'h6C), store(F3_B, 1, 0, 32),
                    store(F3_B, 2, 0, 33), addi(3, 0, 'h7F), store(F3_B, 3, 0, 34),
                    store(F3_B, 2, 0, 35), load(F3_B, 4, 0, 33), load(F3_W, 5, 0, 'h80),
                    store(F3_W, 4, 0, 36), store(F3_W, 5, 0, 40), HALT};
        prog[3] = '{addi(1, 0, 5), addi(2, 0, 5), addi(3, 0, 9), beq(1, 3, 8),
                    store(F3_W, 1, 0, 48), beq(1, 2, 12), store(F3_W, 3, 0, 52),
                    store(F3_W, 3, 0, 56), store(F3_W, 3, 0, 60), HALT, HALT, HALT};
        prog[4] = '{addi(1, 0, 1), jal(5, 12), addi(1, 0, 77), addi(1, 1, 1),
                    store(F3_W, 5, 0, 64), store(F3_W, 1, 0, 68), jal(6, 8),
                    store(F3_W, 1, 0, 72), store(F3_W, 6, 0, 76), HALT, HALT, HALT};
        preload    = '{32'h1357_9BDF, 32'h2468_ACE0, 32'h8123_4567, 32'h0BAD_F00D, 32'h5A5A_0F0F};
        lock_check = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
        exp_count  = '{4, 4, 3, 4, 4};
        exp_index  = '{'{0, 1, 2, 3}, '{4, 5, 6, LOCK_IDX}, '{8, 9, 10, 0},
                       '{12, 13, 14, 15}, '{16, 17, 18, 19}};
        // Two's complement results: -7+12, -7-12, -7*12, -7-2000
        exp_word[0] = '{32'h0000_0005, 32'hFFFF_FFED, 32'hFFFF_FFAC, 32'hFFFF_F829};
        exp_word[1] = '{32'h0000_0082, 32'h0000_0070, 32'h0000_4204, 32'h0000_0000};
        exp_word[2] = '{32'h947F_9411, 32'hFFFF_FF94, 32'h8123_4567, 32'h0000_0000};
        exp_word[3] = '{32'h0000_0005, 32'h0000_0000, 32'h0000_0000, 32'h0000_0009};
        exp_word[4] = '{32'h0000_0008, 32'h0000_0001, 32'h0000_0000, 32'h0000_001C};  // Link pc+4
    endtask

    task automatic report_mismatch(input string what, input cpu_isa_pkg::word_t expected,
                                   input cpu_isa_pkg::word_t actual);
        $display("[ERROR] %s %s: expected %h actual %h", cur_test, what, expected, actual);
        mismatches++;
    endtask

    //////////////////////////////
    // APB master
    task automatic apb_access(input logic write, input cpu_bus_pkg::apb_addr_t addr,
                              input cpu_isa_pkg::word_t wdata,
                              output cpu_isa_pkg::word_t rdata, output logic err);
        logic got;
        int   waited;
        rdata = '0;
        err   = 1'b0;
        got   = 1'b0;
        @(posedge clk);
        #1;
        psel    = 1'b1;                  // Setup phase
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        waited  = 0;
        while (!got && waited < APB_TIMEOUT) begin
            @(negedge clk);
            if (pready) begin
                got   = 1'b1;
                rdata = prdata;
                err   = pslverr;
            end
            @(posedge clk);
            #1;
            waited++;
        end
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        if (!got) begin
            $display("Timeout: APB access at address %h never got pready", addr);
            timeouts++;
        end
    endtask

    task automatic apb_write(input cpu_bus_pkg::apb_addr_t addr, input cpu_isa_pkg::word_t data);
        cpu_isa_pkg::word_t rdata;
        logic               err;
        apb_access(1'b1, addr, data, rdata, err);
        if (err !== 1'b0) report_mismatch($sformatf("pslverr on write to %h", addr), 0, 1);
    endtask

    task automatic run_test(input int t);
        cpu_isa_pkg::word_t rdata;
        logic               err;
        int                 polls;
        cur_test = test_name[t];
        for (int i = 0; i < PROG_WORDS; i++) begin
            apb_write(cpu_bus_pkg::IMEM_BASE + 12'(4 * i), prog[t][i]);
        end
        apb_write(cpu_bus_pkg::DMEM_BASE + 12'(4 * PRELOAD_IDX), preload[t]);
        for (int i = 0; i < exp_count[t]; i++) begin
            apb_write(cpu_bus_pkg::DMEM_BASE + 12'(4 * exp_index[t][i]), 32'h0);  // Known start
        end
        apb_write(cpu_bus_pkg::ADDR_CTRL, 32'h1);
        apb_access(1'b0, cpu_bus_pkg::ADDR_STATUS, '0, rdata, err);
        if (rdata !== 32'h1) report_mismatch("status after start", 32'h1, rdata);
        if (lock_check[t]) begin
            apb_access(1'b1, cpu_bus_pkg::DMEM_BASE + 12'(4 * LOCK_IDX), 32'hDEAD_BEEF, rdata, err);
            if (err !== 1'b1) report_mismatch("pslverr on write while busy", 1, {31'b0, err});
        end
        polls = 0;
        while (rdata !== 32'h2 && polls < RUN_TIMEOUT) begin
            apb_access(1'b0, cpu_bus_pkg::ADDR_STATUS, '0, rdata, err);
            polls++;
        end
        if (rdata !== 32'h2) begin
            $display("Timeout: program %s did not report done", cur_test);
            timeouts++;
        end
        for (int i = 0; i < exp_count[t]; i++) begin
            apb_access(1'b0, cpu_bus_pkg::DMEM_BASE + 12'(4 * exp_index[t][i]), '0, rdata, err);
            if (rdata !== exp_word[t][i]) begin
                report_mismatch($sformatf("dmem[%0d]", exp_index[t][i]), exp_word[t][i], rdata);
            end
        end
    endtask

    initial begin
        cpu_isa_pkg::word_t rdata;
        logic               err;
        rst_n      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        mismatches = 0;
        timeouts   = 0;
        build_table();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        cur_test = "host_port";
        apb_access(1'b0, cpu_bus_pkg::ADDR_STATUS, '0, rdata, err);
        if (rdata !== 32'h0) report_mismatch("status after reset", 32'h0, rdata);
        apb_access(1'b0, 12'h100, '0, rdata, err);             // Gap below the windows
        if (err !== 1'b1) report_mismatch("pslverr on unmapped read", 1, {31'b0, err});
        apb_access(1'b1, 12'hC04, 32'h1, rdata, err);
        if (err !== 1'b1) report_mismatch("pslverr on unmapped write", 1, {31'b0, err});

        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end

        $display("Summary: mismatches=%0d timeouts=%0d", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
